/* src/beamform_pkg.sv */
`default_nettype none

package beamform_pkg;

	// Widths shared by the whole datapath.
	localparam int sample_w = 10;  // Per I or Q component.
	localparam int coef_w = 5;  // One weight, signed.
	localparam int shift_w = 15;  // Element result after clamp.
	localparam int beam_w = 16;  // Combined output after clamp.

	// Input sample component from one antenna element.
	typedef logic signed [sample_w-1:0] sample_t;

	// Complex weight part, cosine or sine.
	typedef logic signed [coef_w-1:0] coef_t;

	// Saturated element output.
	typedef logic signed [shift_w-1:0] shift_t;

	// Saturated array output.
	typedef logic signed [beam_w-1:0] beam_t;

	// Weight slot targeted by a bank write.
	typedef enum logic [1:0] {
		sel_cos_1 = 2'd0,  // Beam 1 cosine.
		sel_sin_1 = 2'd1,  // Beam 1 sine.
		sel_cos_2 = 2'd2,  // Beam 2 cosine.
		sel_sin_2 = 2'd3  // Beam 2 sine.
	} coef_sel_t;

	// Number of weight slots held per element.
	localparam int num_slots = 4;

endpackage

`default_nettype wire

/* src/coef_if.sv */
`default_nettype none

// One element's weight set, held as steady levels by the bank.
interface coef_if import beamform_pkg::*; ();

	coef_t cos_1;  // Beam 1.
	coef_t sin_1;
	coef_t cos_2;  // Beam 2.
	coef_t sin_2;

	modport bank (
		output cos_1,
		output sin_1,
		output cos_2,
		output sin_2
	);

	modport shifter (
		input cos_1,
		input sin_1,
		input cos_2,
		input sin_2
	);

endinterface

`default_nettype wire

/* src/weight_bank.sv */
`default_nettype none

module weight_bank import beamform_pkg::*; #(
	parameter int num_elements = 4
) (
	input  logic                            clock,
	input  logic                            reset,
	input  logic                            wr_en,
	input  logic [$clog2(num_elements)-1:0] wr_elem,
	input  coef_sel_t                       wr_sel,
	input  coef_t                           wr_data,
	coef_if.bank                            coefs [num_elements]
);

	// Four weight registers per element.
	coef_t bank_r [num_elements][num_slots];

	logic wr_hit;

	// Indices past the last element are dropped.
	assign wr_hit = wr_en && (int'(wr_elem) < num_elements);

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int e = 0; e < num_elements; e++) begin
				for (int s = 0; s < num_slots; s++) begin
					bank_r[e][s] <= '0;  // Zero weights mute the array.
				end
			end
		end else if (wr_hit) begin
			bank_r[wr_elem][wr_sel] <= wr_data;  // One slot per strobe.
		end
	end

	// Registers drive the shifters directly, so a write lands one edge later.
	for (genvar e = 0; e < num_elements; e++) begin : g_drive
		assign coefs[e].cos_1 = bank_r[e][sel_cos_1];
		assign coefs[e].sin_1 = bank_r[e][sel_sin_1];
		assign coefs[e].cos_2 = bank_r[e][sel_cos_2];
		assign coefs[e].sin_2 = bank_r[e][sel_sin_2];
	end

endmodule

`default_nettype wire

/* src/phase_shift.sv */
`default_nettype none

module phase_shift import beamform_pkg::*; (
	input  logic    clock,
	input  logic    reset,
	input  sample_t sample_i,
	input  sample_t sample_q,
	coef_if.shifter coefs,
	output shift_t  out_i,
	output shift_t  out_q
);

	// Full precision through the beam sum, no overflow possible.
	localparam int prod_w = sample_w + coef_w;
	localparam int term_w = prod_w + 1;
	localparam int sum_w = prod_w + 2;

	localparam logic signed [sum_w-1:0] shift_max = (2 ** (shift_w - 1)) - 1;
	localparam logic signed [sum_w-1:0] shift_min = -(2 ** (shift_w - 1));

	logic signed [prod_w-1:0] ii_1;
	logic signed [prod_w-1:0] iq_1;
	logic signed [prod_w-1:0] qi_1;
	logic signed [prod_w-1:0] qq_1;
	logic signed [prod_w-1:0] ii_2;
	logic signed [prod_w-1:0] iq_2;
	logic signed [prod_w-1:0] qi_2;
	logic signed [prod_w-1:0] qq_2;

	logic signed [term_w-1:0] i_term_1;
	logic signed [term_w-1:0] q_term_1;
	logic signed [term_w-1:0] i_term_2;
	logic signed [term_w-1:0] q_term_2;

	logic signed [sum_w-1:0] sum_i;
	logic signed [sum_w-1:0] sum_q;

	// Clamp to the 15-bit element range.
	function automatic shift_t clamp(input logic signed [sum_w-1:0] value);
		if (value > shift_max) begin
			return shift_max[shift_w-1:0];
		end
		if (value < shift_min) begin
			return shift_min[shift_w-1:0];
		end
		return value[shift_w-1:0];
	endfunction

	// Beam 1 products.
	assign ii_1 = sample_i * coefs.cos_1;
	assign iq_1 = sample_i * coefs.sin_1;
	assign qi_1 = sample_q * coefs.cos_1;
	assign qq_1 = sample_q * coefs.sin_1;

	// Beam 2 products.
	assign ii_2 = sample_i * coefs.cos_2;
	assign iq_2 = sample_i * coefs.sin_2;
	assign qi_2 = sample_q * coefs.cos_2;
	assign qq_2 = sample_q * coefs.sin_2;

	// Complex multiply by cos - j sin.
	assign i_term_1 = ii_1 + qq_1;
	assign q_term_1 = qi_1 - iq_1;
	assign i_term_2 = ii_2 + qq_2;
	assign q_term_2 = qi_2 - iq_2;

	assign sum_i = i_term_1 + i_term_2;  // Both beams summed.
	assign sum_q = q_term_1 + q_term_2;

	always_ff @(posedge clock) begin
		if (reset) begin
			out_i <= '0;
			out_q <= '0;
		end else begin
			out_i <= clamp(sum_i);
			out_q <= clamp(sum_q);
		end
	end

endmodule

`default_nettype wire

/* src/beam_combiner.sv */
`default_nettype none

module beam_combiner import beamform_pkg::*; #(
	parameter int num_elements = 4
) (
	input  logic   clock,
	input  logic   reset,
	input  shift_t elem_i [num_elements],
	input  shift_t elem_q [num_elements],
	output beam_t  out_i,
	output beam_t  out_q
);

	// Three guard bits cover up to eight elements.
	localparam int sum_w = shift_w + 3;

	localparam logic signed [sum_w-1:0] beam_max = (2 ** (beam_w - 1)) - 1;
	localparam logic signed [sum_w-1:0] beam_min = -(2 ** (beam_w - 1));

	logic signed [sum_w-1:0] sum_i;
	logic signed [sum_w-1:0] sum_q;

	// Clamp to the 16-bit output range.
	function automatic beam_t clamp(input logic signed [sum_w-1:0] value);
		if (value > beam_max) begin
			return beam_max[beam_w-1:0];
		end
		if (value < beam_min) begin
			return beam_min[beam_w-1:0];
		end
		return value[beam_w-1:0];
	endfunction

	// Plain adder chain across all elements.
	always_comb begin
		sum_i = '0;
		sum_q = '0;
		for (int e = 0; e < num_elements; e++) begin
			sum_i = sum_i + elem_i[e];  // Sign extended.
			sum_q = sum_q + elem_q[e];
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			out_i <= '0;
			out_q <= '0;
		end else begin
			out_i <= clamp(sum_i);
			out_q <= clamp(sum_q);
		end
	end

endmodule

`default_nettype wire

/* src/beamformer_top.sv */
`default_nettype none

module beamformer_top import beamform_pkg::*; #(
	parameter int num_elements = 4
) (
	input  logic                            clock,
	input  logic                            reset,
	input  logic                            in_valid,
	input  sample_t                         sample_i [num_elements],
	input  sample_t                         sample_q [num_elements],
	input  logic                            wr_en,
	input  logic [$clog2(num_elements)-1:0] wr_elem,
	input  coef_sel_t                       wr_sel,
	input  coef_t                           wr_data,
	output logic                            out_valid,
	output beam_t                           out_i,
	output beam_t                           out_q
);

	// One weight bundle per element.
	coef_if coefs [num_elements] ();

	shift_t elem_i [num_elements];
	shift_t elem_q [num_elements];

	// Tracks the two register stages of the datapath.
	logic [1:0] valid_pipe;

	weight_bank #(
		.num_elements(num_elements)
	) u_weight_bank (
		.clock  (clock),
		.reset  (reset),
		.wr_en  (wr_en),
		.wr_elem(wr_elem),
		.wr_sel (wr_sel),
		.wr_data(wr_data),
		.coefs  (coefs)
	);

	for (genvar e = 0; e < num_elements; e++) begin : g_elem
		phase_shift u_phase_shift (
			.clock   (clock),
			.reset   (reset),
			.sample_i(sample_i[e]),
			.sample_q(sample_q[e]),
			.coefs   (coefs[e]),
			.out_i   (elem_i[e]),
			.out_q   (elem_q[e])
		);
	end

	beam_combiner #(
		.num_elements(num_elements)
	) u_beam_combiner (
		.clock (clock),
		.reset (reset),
		.elem_i(elem_i),
		.elem_q(elem_q),
		.out_i (out_i),
		.out_q (out_q)
	);

	// Stage 0 lines up with the element registers, stage 1 with the output.
	always_ff @(posedge clock) begin
		if (reset) begin
			valid_pipe <= '0;
		end else begin
			valid_pipe <= {valid_pipe[0], in_valid};
		end
	end

	assign out_valid = valid_pipe[1];

endmodule

`default_nettype wire

/* include/bf_model.svh */
`ifndef BF_MODEL_SVH
`define BF_MODEL_SVH

// Clamp a value to a signed range of the given width.
function automatic int bf_sat(input int value, input int width);
	int hi;
	int lo;
	hi = (1 << (width - 1)) - 1;
	lo = -(1 << (width - 1));
	if (value > hi) begin
		return hi;
	end
	if (value < lo) begin
		return lo;
	end
	return value;
endfunction

// Element I result: i*cos + q*sin for each beam, summed and clamped.
function automatic int bf_elem_i(input int i, input int q,
		input int cos_1, input int sin_1, input int cos_2, input int sin_2);
	int sum;
	sum = (i * cos_1 + q * sin_1) + (i * cos_2 + q * sin_2);
	return bf_sat(sum, beamform_pkg::shift_w);
endfunction

// Element Q result: q*cos - i*sin for each beam.
function automatic int bf_elem_q(input int i, input int q,
		input int cos_1, input int sin_1, input int cos_2, input int sin_2);
	int sum;
	sum = (q * cos_1 - i * sin_1) + (q * cos_2 - i * sin_2);
	return bf_sat(sum, beamform_pkg::shift_w);
endfunction

// Array output from the element results of one component.
function automatic int bf_combine(input int elems[]);
	int sum;
	sum = 0;
	foreach (elems[e]) begin
		sum += elems[e];
	end
	return bf_sat(sum, beamform_pkg::beam_w);
endfunction

`endif

/* tb/tb_beamformer.sv */
`default_nettype none

module tb_beamformer import beamform_pkg::*; ();

	`include "bf_model.svh"

	localparam int num_elements = 4;
	localparam int reset_cycles = 10;
	localparam int lat_sets = 60;  // Sets in the latency test.
	localparam int rand_rounds = 8;  // Weight reloads in the random test.
	localparam int rand_sets = 20;  // Sample sets after each reload.
	localparam int zero_sets = 30;
	localparam int wr_cycles = num_elements * num_slots;
	// Worst case, with every latency gap at its longest.
	localparam int test_cycles = reset_cycles + 3 + wr_cycles + lat_sets * 4
		+ rand_rounds * (wr_cycles + rand_sets) + 4 * (wr_cycles + 4)
		+ wr_cycles + zero_sets + 4;

	localparam int max_sample = (1 << (sample_w - 1)) - 1;
	localparam int min_sample = -(1 << (sample_w - 1));

	logic                            clock = 1'b0;
	logic                            reset;
	logic                            in_valid;
	sample_t                         sample_i [num_elements];
	sample_t                         sample_q [num_elements];
	logic                            wr_en;
	logic [$clog2(num_elements)-1:0] wr_elem;
	coef_sel_t                       wr_sel;
	coef_t                           wr_data;
	logic                            out_valid;
	beam_t                           out_i;
	beam_t                           out_q;

	logic [31:0] lfsr = 32'h1659_159e;
	int shadow [num_elements][num_slots];  // Weights as the bank should hold them.
	int next_i [num_elements];  // Samples for the next driven cycle.
	int next_q [num_elements];
	int exp_i_q [$];
	int exp_q_q [$];
	int exp_cycle_q [$];  // Cycle in which each result is due.
	int want_i;
	int want_q;
	int want_cycle;
	int cycle_count = 0;
	int outputs_seen = 0;

	beamformer_top #(
		.num_elements(num_elements)
	) dut (
		.clock    (clock),
		.reset    (reset),
		.in_valid (in_valid),
		.sample_i (sample_i),
		.sample_q (sample_q),
		.wr_en    (wr_en),
		.wr_elem  (wr_elem),
		.wr_sel   (wr_sel),
		.wr_data  (wr_data),
		.out_valid(out_valid),
		.out_i    (out_i),
		.out_q    (out_q)
	);

	always #5 clock = ~clock;

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;  // Rising edges so far.
	end

	// One Galois step, taps 32, 22, 2 and 1.
	function automatic bit lfsr_step();
		bit taken;
		taken = lfsr[0];
		lfsr = lfsr >> 1;
		if (taken) begin
			lfsr = lfsr ^ 32'h8020_0003;
		end
		return taken;
	endfunction

	function automatic int rand_bits(input int count);
		int value;
		value = 0;
		for (int b = 0; b < count; b++) begin
			value = (value << 1) | int'(lfsr_step());
		end
		return value;
	endfunction

	// Two's complement value of the given width.
	function automatic int rand_signed(input int width);
		int raw;
		raw = rand_bits(width);
		if (raw >= (1 << (width - 1))) begin
			raw = raw - (1 << width);
		end
		return raw;
	endfunction

	task automatic check_value(input string name, input int actual, input int expected);
		if (actual != expected) begin
			$display("FAIL at %0t: %s actual %0d expected %0d", $time, name, actual, expected);
			$display("Finished with errors");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic stop_with_error(input string reason);
		$display("ERROR at %0t: %s", $time, reason);
		$display("Finished with errors");
		$fatal(1, "run aborted");
	endtask

	// Expected array output for the samples in next_i and next_q.
	task automatic push_expected();
		int ei [];
		int eq [];
		ei = new[num_elements];
		eq = new[num_elements];
		for (int e = 0; e < num_elements; e++) begin
			ei[e] = bf_elem_i(next_i[e], next_q[e], shadow[e][sel_cos_1], shadow[e][sel_sin_1],
				shadow[e][sel_cos_2], shadow[e][sel_sin_2]);
			eq[e] = bf_elem_q(next_i[e], next_q[e], shadow[e][sel_cos_1], shadow[e][sel_sin_1],
				shadow[e][sel_cos_2], shadow[e][sel_sin_2]);
		end
		exp_i_q.push_back(bf_combine(ei));
		exp_q_q.push_back(bf_combine(eq));
		exp_cycle_q.push_back(cycle_count + 2);  // Two edges after the sample edge.
	endtask

	task automatic drive_cycle(input bit valid, input bit wr, input int elem, input int sel,
			input int data);
		@(posedge clock);
		#1;
		in_valid = valid;
		wr_en = wr;
		wr_elem = elem[$clog2(num_elements)-1:0];
		wr_sel = coef_sel_t'(sel);
		wr_data = coef_t'(data);
		for (int e = 0; e < num_elements; e++) begin
			sample_i[e] = sample_t'(next_i[e]);
			sample_q[e] = sample_t'(next_q[e]);
		end
		// A sample in the write cycle still sees the old weight.
		if (valid) begin
			push_expected();
		end
		if (wr) begin
			shadow[elem][sel] = data;
		end
	endtask

	task automatic load_samples(input bit random);
		for (int e = 0; e < num_elements; e++) begin
			next_i[e] = random ? rand_signed(sample_w) : 0;
			next_q[e] = random ? rand_signed(sample_w) : 0;
		end
	endtask

	task automatic idle_cycle(input bit garbage);
		load_samples(garbage);
		drive_cycle(1'b0, 1'b0, 0, 0, 0);
	endtask

	task automatic send_random_set();
		load_samples(1'b1);
		drive_cycle(1'b1, 1'b0, 0, 0, 0);
	endtask

	// Every slot of every element, one write per cycle.
	task automatic write_all(input bit random, input int value);
		for (int e = 0; e < num_elements; e++) begin
			for (int s = 0; s < num_slots; s++) begin
				load_samples(1'b0);
				drive_cycle(1'b0, 1'b1, e, s, random ? rand_signed(coef_w) : value);
			end
		end
	endtask

	// Four full-scale I/Q corners on the first active elements, zero elsewhere.
	task automatic send_full_scale(input int active);
		for (int p = 0; p < 4; p++) begin
			for (int e = 0; e < num_elements; e++) begin
				next_i[e] = (e >= active) ? 0 : ((p == 0 || p == 2) ? max_sample : min_sample);
				next_q[e] = (e >= active) ? 0 : ((p == 0 || p == 3) ? max_sample : min_sample);
			end
			drive_cycle(1'b1, 1'b0, 0, 0, 0);
		end
	endtask

	// Outputs settle well before the falling edge.
	always @(negedge clock) begin
		if (reset) begin
			check_value("out_valid", int'(out_valid), 0);
		end
		if (out_valid) begin
			if (exp_i_q.size() == 0) begin
				stop_with_error("out_valid was high with no sample set outstanding");
			end else begin
				want_i = exp_i_q.pop_front();
				want_q = exp_q_q.pop_front();
				want_cycle = exp_cycle_q.pop_front();
				check_value("out_valid cycle", cycle_count, want_cycle);
				check_value("out_i", int'(out_i), want_i);
				check_value("out_q", int'(out_q), want_q);
				outputs_seen++;
			end
		end else if (outputs_seen == 0) begin
			check_value("out_i", int'(out_i), 0);  // Quiet until the first result.
			check_value("out_q", int'(out_q), 0);
		end
	end

	initial begin
		#((test_cycles + 100) * 10);
		stop_with_error("watchdog expired before the tests completed");
	end

	initial begin
		reset = 1'b1;
		in_valid = 1'b0;
		wr_en = 1'b0;
		wr_elem = '0;
		wr_sel = sel_cos_1;
		wr_data = '0;
		for (int e = 0; e < num_elements; e++) begin
			sample_i[e] = '0;
			sample_q[e] = '0;
			next_i[e] = 0;
			next_q[e] = 0;
			for (int s = 0; s < num_slots; s++) begin
				shadow[e][s] = 0;
			end
		end
		repeat (reset_cycles) @(posedge clock);
		#1;
		reset = 1'b0;
		repeat (3) idle_cycle(1'b0);

		// Latency and order, with back-to-back sets and gaps.
		write_all(1'b1, 0);
		for (int n = 0; n < lat_sets; n++) begin
			send_random_set();
			repeat (rand_bits(2)) idle_cycle(1'b1);
		end

		// Weight writes interleaved with sample sets.
		for (int r = 0; r < rand_rounds; r++) begin
			for (int e = 0; e < num_elements; e++) begin
				for (int s = 0; s < num_slots; s++) begin
					load_samples(1'b1);
					drive_cycle(1'b1, 1'b1, e, s, rand_signed(coef_w));
				end
			end
			repeat (rand_sets) send_random_set();
		end

		// Two elements clamp, the sum stays in range.
		write_all(1'b0, 15);
		send_full_scale(2);
		write_all(1'b0, -16);
		send_full_scale(2);

		// All elements clamp and so does the array output.
		write_all(1'b0, 15);
		send_full_scale(num_elements);
		write_all(1'b0, -16);
		send_full_scale(num_elements);

		write_all(1'b0, 0);
		repeat (zero_sets) send_random_set();

		repeat (4) idle_cycle(1'b0);
		if (exp_i_q.size() != 0) begin
			stop_with_error("sample sets were sent but their results never came out");
		end else begin
			$display("Finished with no errors");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* tb.f */
+incdir+include
src/beamform_pkg.sv
src/coef_if.sv
src/weight_bank.sv
src/phase_shift.sv
src/beam_combiner.sv
src/beamformer_top.sv
tb/tb_beamformer.sv

/* Makefile */
TOP = tb_beamformer
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --top-module beamformer_top \
		src/beamform_pkg.sv src/coef_if.sv src/weight_bank.sv \
		src/phase_shift.sv src/beam_combiner.sv src/beamformer_top.sv

sim:
	verilator --binary --timing -f tb.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^Finished with no errors$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
